//--- logic/cache_controller.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_controller
    import rv_mem_pkg::*, cache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  mem_req_t                req,
    input  logic                    lookup_hit,
    input  logic                    line_valid,
    input  dram_beat_t              dram_beat,
    input  logic [`CACHE_TAG_W-1:0] victim_tag,
    output mem_req_t                cur_req,
    output dram_req_t               dram_req,
    output logic                    fill_done,
    output logic                    access_strobe,
    output logic                    busy
);

    ctrl_state_e                state;
    dram_cmd_e                  dram_cmd;
    mem_req_t                   req_q;
    logic [`CACHE_OFFSET_W-1:0] beat_cnt;
    logic                       last_beat;
    cache_addr_t                cur_addr;
    logic                       evicting;

    ////////////////////////////////////////
    // Request hold
    ////////////////////////////////////////

    // Accepted request is captured only while idle
    always_ff @(posedge clk) begin
        if (state == st_idle && req_valid)
            req_q <= req;
    end

    // Idle passes the live request so a hit completes in one cycle
    assign cur_req  = (state == st_idle) ? req : req_q;
    assign cur_addr = cache_addr_t'(cur_req.addr);

    ////////////////////////////////////////
    // Beat counting
    ////////////////////////////////////////

    // Counter wraps to zero at the end of every full burst
    always_ff @(posedge clk) begin
        if (rst)
            beat_cnt <= '0;
        else if (dram_beat.valid)
            beat_cnt <= beat_cnt + 1'b1;
    end

    assign last_beat = dram_beat.valid && (beat_cnt == '1);

    ////////////////////////////////////////
    // Miss FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            dram_cmd <= cmd_none;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid && !lookup_hit) begin
                        if (line_valid) begin       // Victim goes back first
                            state    <= st_evict_wait;
                            dram_cmd <= cmd_write;
                        end else begin
                            state    <= st_fill_wait;
                            dram_cmd <= cmd_read;
                        end
                    end
                end
                st_evict_wait: begin
                    if (dram_beat.valid)
                        state <= st_evict_burst;
                end
                st_evict_burst: begin
                    if (last_beat) begin
                        state    <= st_fill_wait;
                        dram_cmd <= cmd_none;       // DRAM must see the drop
                    end
                end
                st_fill_wait: begin
                    // One idle cycle after a write-back, then the read goes out
                    if (dram_cmd == cmd_none)
                        dram_cmd <= cmd_read;
                    else if (dram_beat.valid)
                        state <= st_fill_burst;
                end
                st_fill_burst: begin
                    if (last_beat) begin
                        state    <= st_finish;
                        dram_cmd <= cmd_none;
                    end
                end
                st_finish: state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    assign evicting = (state == st_evict_wait) || (state == st_evict_burst);

    // Victim block during write-back, requested block otherwise
    assign dram_req.cmd   = dram_cmd;
    assign dram_req.block = evicting ? {victim_tag, cur_addr.index}
                                     : {cur_addr.tag, cur_addr.index};

    assign fill_done     = (state == st_fill_burst) && last_beat;
    assign access_strobe = ((state == st_idle) && req_valid && lookup_hit)
                           || (state == st_finish);
    assign busy          = (state != st_idle);     // Pipeline freeze

endmodule

//--- logic/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

    // Address split for a direct-mapped lookup
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
    } cache_addr_t;

    // Miss sequencing
    typedef enum logic [2:0] {
        st_idle,
        st_evict_wait,                      // Write command out, latency running
        st_evict_burst,
        st_fill_wait,                       // Read command out, latency running
        st_fill_burst,
        st_finish                           // Block present, do the access
    } ctrl_state_e;

    typedef enum logic [1:0] {
        cmd_none  = 2'd0,
        cmd_read  = 2'd1,
        cmd_write = 2'd2
    } dram_cmd_e;

    // Held stable by the controller for a whole burst
    typedef struct packed {
        dram_cmd_e                                cmd;
        logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0] block;
    } dram_req_t;

    // One byte of a block burst
    typedef struct packed {
        logic                       valid;
        logic [`CACHE_OFFSET_W-1:0] idx;
        logic [7:0]                 data;
    } dram_beat_t;

endpackage

//--- logic/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

////////////////////////////////////////
// Cache geometry
////////////////////////////////////////
`define CACHE_ADDR_W      32
`define CACHE_BLOCK_BYTES 16                // Power of two
`define CACHE_LINES       8                 // Direct mapped
`define CACHE_OFFSET_W    ($clog2(`CACHE_BLOCK_BYTES))
`define CACHE_INDEX_W     ($clog2(`CACHE_LINES))
`define CACHE_TAG_W       (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

////////////////////////////////////////
// Backing DRAM
////////////////////////////////////////
`define DRAM_BYTES        1024
`define DRAM_LATENCY      4                 // Wait cycles before first beat

`endif

//--- logic/cache_store.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_store
    import rv_mem_pkg::*, cache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  mem_req_t                cur_req,
    input  dram_beat_t              dram_beat,
    input  logic                    fill_done,
    input  logic                    access_strobe,
    output logic                    lookup_hit,
    output logic                    line_valid,
    output logic [`CACHE_TAG_W-1:0] victim_tag,
    output logic [7:0]              wr_byte,
    output logic                    resp_valid,
    output mem_resp_t               resp
);

    logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid;
    logic [7:0]              data_mem [`CACHE_LINES][`CACHE_BLOCK_BYTES];

    cache_addr_t             addr;
    logic [31:0]             load_word;     // Aligned word around the access
    logic [31:0]             load_lane;     // Addressed bytes moved to bit 0
    logic [31:0]             load_data;
    logic [3:0]              byte_en;
    logic [31:0]             store_lanes;

    assign addr = cache_addr_t'(cur_req.addr);

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    assign line_valid = valid[addr.index];
    assign victim_tag = tag_mem[addr.index];
    assign lookup_hit = line_valid && (victim_tag == addr.tag);

    // Victim byte for the write-back beat in flight
    assign wr_byte = data_mem[addr.index][dram_beat.idx];

    always_ff @(posedge clk) begin
        if (rst)
            valid <= '0;
        else if (fill_done)
            valid[addr.index] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (fill_done)
            tag_mem[addr.index] <= addr.tag;
    end

    ////////////////////////////////////////
    // Store merge, little endian
    ////////////////////////////////////////

    always_comb begin
        case (cur_req.width)
            w_byte, w_byte_u: byte_en = 4'b0001 << addr.offset[1:0];
            w_half, w_half_u: byte_en = 4'b0011 << addr.offset[1:0];
            default:          byte_en = 4'b1111;
        endcase
        store_lanes = cur_req.data << {addr.offset[1:0], 3'b000};
    end

    // Write beats echo the victim byte, so that write is harmless
    always_ff @(posedge clk) begin
        if (dram_beat.valid)
            data_mem[addr.index][dram_beat.idx] <= dram_beat.data;
        if (access_strobe && cur_req.opcode == op_store) begin
            for (int k = 0; k < 4; k++) begin
                if (byte_en[k])
                    data_mem[addr.index][{addr.offset[`CACHE_OFFSET_W-1:2], 2'(k)}]
                        <= store_lanes[8*k +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // Load extraction
    ////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < 4; k++)
            load_word[8*k +: 8] = data_mem[addr.index][{addr.offset[`CACHE_OFFSET_W-1:2], 2'(k)}];
    end

    assign load_lane = load_word >> {addr.offset[1:0], 3'b000};

    always_comb begin
        case (cur_req.width)
            w_byte:   load_data = {{24{load_lane[7]}}, load_lane[7:0]};
            w_half:   load_data = {{16{load_lane[15]}}, load_lane[15:0]};
            w_byte_u: load_data = {24'b0, load_lane[7:0]};
            w_half_u: load_data = {16'b0, load_lane[15:0]};
            default:  load_data = load_word;    // LW
        endcase
    end

    // Response one cycle after the access
    always_ff @(posedge clk) begin
        if (rst)
            resp_valid <= 1'b0;
        else
            resp_valid <= access_strobe;
    end

    always_ff @(posedge clk) begin
        if (access_strobe)
            resp.data <= load_data;
    end

endmodule

//--- logic/dram_model.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module dram_model
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  dram_req_t  dram_req,
    input  logic [7:0] wr_byte,
    output dram_beat_t dram_beat
);

    localparam int cnt_max  = `DRAM_LATENCY + `CACHE_BLOCK_BYTES;
    localparam int cnt_w    = $clog2(cnt_max + 1);
    localparam int dram_aw  = $clog2(`DRAM_BYTES);
    localparam int offset_w = `CACHE_OFFSET_W;

    localparam logic [cnt_w-1:0] first_beat = cnt_w'(`DRAM_LATENCY);
    localparam logic [cnt_w-1:0] end_cnt    = cnt_w'(cnt_max);

    logic [7:0]          mem [`DRAM_BYTES];
    logic [cnt_w-1:0]    cnt;
    logic                active;
    logic                beat_on;
    logic [offset_w-1:0] beat_idx;
    logic [dram_aw-1:0]  byte_addr;

    initial begin
        for (int i = 0; i < `DRAM_BYTES; i++)
            mem[i] = '0;
    end

    assign active = (dram_req.cmd != cmd_none);

    // Latency then one beat per cycle, parked at the end until the drop
    always_ff @(posedge clk) begin
        if (rst || !active)
            cnt <= '0;
        else if (cnt != end_cnt)
            cnt <= cnt + 1'b1;
    end

    assign beat_on   = active && (cnt >= first_beat) && (cnt < end_cnt);
    assign beat_idx  = offset_w'(cnt - first_beat);
    assign byte_addr = dram_aw'({dram_req.block, beat_idx});   // Wraps above DRAM size

    ////////////////////////////////////////
    // Beat out, write in
    ////////////////////////////////////////

    assign dram_beat.valid = beat_on;
    assign dram_beat.idx   = beat_idx;
    assign dram_beat.data  = (dram_req.cmd == cmd_write) ? wr_byte : mem[byte_addr];

    always_ff @(posedge clk) begin
        if (beat_on && dram_req.cmd == cmd_write)
            mem[byte_addr] <= wr_byte;
    end

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module mem_stage
    import rv_mem_pkg::*, cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  mem_req_t  req,
    output logic      resp_valid,
    output mem_resp_t resp,
    output logic      busy
);

    mem_req_t                cur_req;
    dram_req_t               dram_req;
    dram_beat_t              dram_beat;
    logic                    lookup_hit;
    logic                    line_valid;
    logic [`CACHE_TAG_W-1:0] victim_tag;
    logic                    fill_done;
    logic                    access_strobe;
    logic [7:0]              wr_byte;

    cache_controller u_ctrl (
        .clk, .rst, .req_valid, .req,
        .lookup_hit, .line_valid, .dram_beat, .victim_tag,
        .cur_req, .dram_req, .fill_done, .access_strobe, .busy
    );

    // Tag, valid and data arrays
    cache_store u_store (
        .clk, .rst, .cur_req, .dram_beat, .fill_done, .access_strobe,
        .lookup_hit, .line_valid, .victim_tag, .wr_byte,
        .resp_valid, .resp
    );

    dram_model u_dram (
        .clk, .rst, .dram_req, .wr_byte, .dram_beat
    );

endmodule

//--- logic/rv_mem_pkg.sv
`include "cache_settings.svh"

package rv_mem_pkg;

    // Major opcodes of the RV32I load and store groups
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } mem_opcode_e;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        w_byte   = 3'b000,                  // LB / SB
        w_half   = 3'b001,                  // LH / SH
        w_word   = 3'b010,                  // LW / SW
        w_byte_u = 3'b100,                  // LBU
        w_half_u = 3'b101                   // LHU
    } mem_width_e;

    // Request from the execute side
    typedef struct packed {
        mem_opcode_e               opcode;
        mem_width_e                width;
        logic [`CACHE_ADDR_W-1:0]  addr;
        logic [31:0]               data;    // Store data, low bytes first
    } mem_req_t;

    // Load result, already extended
    typedef struct packed {
        logic [31:0] data;
    } mem_resp_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module tb_mem_stage -f tb.f -o tb_mem_stage_sim
if [ $? -ne 0 ]; then echo "Verilator build failed"; exit 1; fi

./obj_dir/tb_mem_stage_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then echo "Simulation exited with status $status"; exit 1; fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then exit 1; fi
exit 0

//--- tb.f
+incdir+logic
logic/rv_mem_pkg.sv
logic/cache_pkg.sv
logic/cache_controller.sv
logic/cache_store.sv
logic/dram_model.sv
logic/mem_stage.sv
testbench/mem_stage_monitor.sv
testbench/mem_stage_checker.sv
testbench/tb_mem_stage.sv

//--- testbench/mem_stage_checker.sv
`timescale 1ns/1ps

module mem_stage_checker
    import rv_mem_pkg::*, cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  mem_req_t  req,
    input  logic      resp_valid,
    input  logic      busy,
    input  logic      line_valid,
    input  dram_req_t dram_req
);

    int   assert_errors = 0;
    logic outstanding;                      // Request accepted, response not yet seen
    logic aligned;

    always_ff @(posedge clk) begin
        if (rst)
            outstanding <= 1'b0;
        else if (req_valid)
            outstanding <= 1'b1;
        else if (resp_valid)
            outstanding <= 1'b0;
    end

    always_comb begin
        case (req.width)
            w_word:           aligned = (req.addr[1:0] == 2'b00);
            w_half, w_half_u: aligned = (req.addr[0] == 1'b0);
            default:          aligned = 1'b1;
        endcase
    end

    ////////////////////////////////////////
    // Protocol
    ////////////////////////////////////////

    a_reset_state: assert property (@(posedge clk)
        rst |=> (!busy && !resp_valid && !line_valid && dram_req.cmd == cmd_none))
        else begin
            assert_errors++;
            $error("State after reset is not idle");
        end

    // Nothing moves while no request is in flight
    a_quiet_idle: assert property (@(posedge clk) disable iff (rst)
        (!outstanding && !req_valid) |-> (!busy && !resp_valid))
        else begin
            assert_errors++;
            $error("busy or resp_valid high with no request in flight");
        end

    a_strobe_rules: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> (!busy && !outstanding))
        else begin
            assert_errors++;
            $error("Request strobed while busy or a response was pending");
        end

    a_single_strobe: assert property (@(posedge clk) disable iff (rst)
        req_valid |=> !req_valid)
        else begin
            assert_errors++;
            $error("req_valid held longer than one cycle");
        end

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> aligned)
        else begin
            assert_errors++;
            $error("Misaligned access on the request port");
        end

endmodule

bind mem_stage mem_stage_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .resp_valid (resp_valid),
    .busy       (busy),
    .line_valid (line_valid),
    .dram_req   (dram_req)
);

//--- testbench/mem_stage_monitor.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module mem_stage_monitor
    import rv_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  mem_req_t  req,
    input  logic      expect_hit,
    input  logic      resp_valid,
    input  mem_resp_t resp,
    input  logic      busy,
    output int        errors
);

    localparam int ref_aw = $clog2(`DRAM_BYTES);

    logic [7:0] ref_mem [`DRAM_BYTES];      // Byte image of what memory should hold
    mem_req_t   pend_req;
    logic       pend = 1'b0;
    logic       pend_hit;
    int         lat;
    int         err_cnt = 0;

    assign errors = err_cnt;

    // Little endian, extended by funct3
    function automatic logic [31:0] predict_load(input mem_req_t r);
        logic [31:0]       w;
        logic [ref_aw-1:0] idx;
        for (int i = 0; i < 4; i++) begin
            idx = ref_aw'(r.addr + 32'(i));
            w[8*i +: 8] = ref_mem[idx];
        end
        case (r.width)
            w_byte:   return {{24{w[7]}}, w[7:0]};
            w_half:   return {{16{w[15]}}, w[15:0]};
            w_byte_u: return {24'b0, w[7:0]};
            w_half_u: return {16'b0, w[15:0]};
            default:  return w;
        endcase
    endfunction

    task automatic apply_store(input mem_req_t r);
        int                n;
        logic [ref_aw-1:0] idx;
        case (r.width)
            w_byte, w_byte_u: n = 1;
            w_half, w_half_u: n = 2;
            default:          n = 4;
        endcase
        for (int i = 0; i < n; i++) begin
            idx = ref_aw'(r.addr + 32'(i));
            ref_mem[idx] = r.data[8*i +: 8];
        end
    endtask

    ////////////////////////////////////////
    // Response checking
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            pend = 1'b0;
            for (int i = 0; i < `DRAM_BYTES; i++)
                ref_mem[i] = 8'h00;         // DRAM model starts cleared
        end else begin
            if (pend) begin
                lat = lat + 1;
                if (resp_valid) begin
                    if (pend_req.opcode == op_load && resp.data !== predict_load(pend_req)) begin
                        err_cnt++;
                        $display("Mismatch at %0t: resp.data expected %08h, got %08h (addr %08h)",
                                 $time, predict_load(pend_req), resp.data, pend_req.addr);
                    end
                    if (busy) begin
                        err_cnt++;
                        $display("busy still high in the response cycle at %0t", $time);
                    end
                    if (pend_hit && lat != 1) begin
                        err_cnt++;
                        $display("Expected a hit at %0t, but the response took %0d cycles",
                                 $time, lat);
                    end else if (!pend_hit && lat == 1) begin
                        err_cnt++;
                        $display("Expected a miss at %0t, but the response came after one cycle",
                                 $time);
                    end
                    pend = 1'b0;
                end else if (!busy) begin
                    err_cnt++;
                    $display("busy low at %0t while a miss was still in progress", $time);
                end
            end else if (resp_valid) begin
                err_cnt++;
                $display("resp_valid at %0t with no request in flight", $time);
            end
            if (req_valid) begin
                pend_req = req;
                pend_hit = expect_hit;
                pend     = 1'b1;
                lat      = 0;
                if (req.opcode == op_store)
                    apply_store(req);
            end
        end
    end

endmodule

//--- testbench/tb_mem_stage.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module tb_mem_stage
    import rv_mem_pkg::*;
();

    // Worst miss plus strobe and gap cycles per entry
    localparam int entry_cycles = 2 * (`DRAM_LATENCY + `CACHE_BLOCK_BYTES) + 8;

    typedef struct packed {
        mem_opcode_e opcode;
        mem_width_e  width;
        logic [31:0] addr;
        logic [31:0] data;
        logic        rand_data;             // Replace data with the next random word
        logic        expect_hit;
    } stim_t;

    logic      clk;
    logic      rst;
    logic      req_valid;
    mem_req_t  req;
    logic      expect_hit;
    logic      resp_valid;
    mem_resp_t resp;
    logic      busy;
    int        mon_errors;
    logic      table_ready = 1'b0;
    logic [31:0] rng = 32'd46;
    stim_t     stim_q [$];

    mem_stage UUT (
        .clk, .rst, .req_valid, .req, .resp_valid, .resp, .busy
    );

    mem_stage_monitor u_monitor (
        .clk, .rst, .req_valid, .req, .expect_hit, .resp_valid, .resp, .busy,
        .errors (mon_errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_entry(input mem_opcode_e op, input mem_width_e w, input logic [31:0] a,
                             input logic [31:0] d, input logic rnd, input logic hit);
        stim_t e;
        e.opcode     = op;
        e.width      = w;
        e.addr       = a;
        e.data       = d;
        e.rand_data  = rnd;
        e.expect_hit = hit;
        stim_q.push_back(e);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    initial begin
        // Cold line, then hits on the same block
        add_entry(op_store, w_word,   32'h040, 32'hDEADBEEF, 1'b0, 1'b0);
        add_entry(op_load,  w_word,   32'h040, 32'h0,        1'b0, 1'b1);
        add_entry(op_store, w_byte,   32'h041, 32'h000000A5, 1'b0, 1'b1);
        add_entry(op_store, w_half,   32'h042, 32'h00001234, 1'b0, 1'b1);
        add_entry(op_load,  w_word,   32'h040, 32'h0,        1'b0, 1'b1);
        add_entry(op_store, w_byte,   32'h043, 32'h00000080, 1'b0, 1'b1);
        add_entry(op_load,  w_word,   32'h040, 32'h0,        1'b0, 1'b1);
        // Sign and zero extension
        add_entry(op_store, w_word,   32'h044, 32'h8081F0FF, 1'b0, 1'b1);
        add_entry(op_load,  w_byte,   32'h044, 32'h0,        1'b0, 1'b1);
        add_entry(op_load,  w_byte_u, 32'h044, 32'h0,        1'b0, 1'b1);
        add_entry(op_load,  w_half,   32'h046, 32'h0,        1'b0, 1'b1);
        add_entry(op_load,  w_half_u, 32'h046, 32'h0,        1'b0, 1'b1);
        add_entry(op_load,  w_byte,   32'h045, 32'h0,        1'b0, 1'b1);
        add_entry(op_load,  w_byte_u, 32'h047, 32'h0,        1'b0, 1'b1);
        // Index 5 under three tags
        add_entry(op_store, w_word,   32'h050, 32'h11112222, 1'b0, 1'b0);
        add_entry(op_store, w_word,   32'h0D0, 32'h33334444, 1'b0, 1'b0);
        add_entry(op_load,  w_word,   32'h050, 32'h0,        1'b0, 1'b0);
        add_entry(op_load,  w_word,   32'h0D0, 32'h0,        1'b0, 1'b0);
        add_entry(op_load,  w_word,   32'h050, 32'h0,        1'b0, 1'b0);
        add_entry(op_store, w_half,   32'h1D2, 32'h0000BEEF, 1'b0, 1'b0);
        add_entry(op_load,  w_word,   32'h0D0, 32'h0,        1'b0, 1'b0);
        add_entry(op_load,  w_half_u, 32'h1D2, 32'h0,        1'b0, 1'b0);
        add_entry(op_load,  w_word,   32'h3F0, 32'h0,        1'b0, 1'b0);
        // Random data over index 2
        add_entry(op_store, w_word,   32'h020, 32'h0,        1'b1, 1'b0);
        add_entry(op_store, w_byte,   32'h0A5, 32'h0,        1'b1, 1'b0);
        add_entry(op_load,  w_word,   32'h020, 32'h0,        1'b0, 1'b0);
        add_entry(op_store, w_word,   32'h124, 32'h0,        1'b1, 1'b0);
        add_entry(op_load,  w_byte_u, 32'h0A5, 32'h0,        1'b0, 1'b0);
        add_entry(op_load,  w_word,   32'h124, 32'h0,        1'b0, 1'b0);
        add_entry(op_store, w_byte,   32'h1A3, 32'h0,        1'b1, 1'b0);
        add_entry(op_load,  w_byte,   32'h1A3, 32'h0,        1'b0, 1'b1);
        add_entry(op_load,  w_word,   32'h020, 32'h0,        1'b0, 1'b0);
        add_entry(op_store, w_word,   32'h028, 32'h0,        1'b1, 1'b1);
        add_entry(op_load,  w_word,   32'h028, 32'h0,        1'b0, 1'b1);
        table_ready = 1'b1;
    end

    ////////////////////////////////////////
    // Drive and report
    ////////////////////////////////////////

    initial begin
        stim_t e;
        int    total;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        expect_hit = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        repeat (4) @(posedge clk);          // Quiet period after reset
        wait (table_ready);
        foreach (stim_q[i]) begin
            e = stim_q[i];
            if (e.rand_data) begin
                rng    = xorshift32(rng);
                e.data = rng;
            end
            @(posedge clk);
            #1;
            req.opcode = e.opcode;
            req.width  = e.width;
            req.addr   = e.addr;
            req.data   = e.data;
            req_valid  = 1'b1;
            expect_hit = e.expect_hit;
            @(posedge clk);
            #1;
            req_valid  = 1'b0;
            expect_hit = 1'b0;
            while (!resp_valid) begin
                @(posedge clk);
                #1;
            end
        end
        repeat (2) @(posedge clk);
        total = mon_errors + UUT.u_checker.assert_errors;
        $display("Errors: %0d monitor, %0d assertion, %0d total",
                 mon_errors, UUT.u_checker.assert_errors, total);
        if (total == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // Watchdog
    initial begin
        int limit;
        wait (table_ready);
        limit = stim_q.size() * entry_cycles + 100;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Errors: %0d monitor, %0d assertion at timeout",
                 mon_errors, UUT.u_checker.assert_errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
